//--- verilog/plru_pkg.sv
package plru_pkg;

  //--------------------------------------------------------------------
  // Sizes
  //--------------------------------------------------------------------

  // Entries in the instruction micro-TLB
  localparam int ENTRY_NUM = 32;

  // Bits of an entry index
  localparam int IDX_W = $clog2(ENTRY_NUM);

  // One node bit per internal node of the binary tree
  localparam int TREE_W = ENTRY_NUM - 1;

  //--------------------------------------------------------------------
  // Types
  //--------------------------------------------------------------------

  // One bit per entry, bit n is entry n
  typedef logic [ENTRY_NUM-1:0] entry_vec_t;

  typedef logic [IDX_W-1:0] entry_idx_t;

  // Heap order, node 0 is the root
  // Children of node n are 2n+1 and 2n+2
  // A node bit of 0 sends the victim search to the lower half
  typedef logic [TREE_W-1:0] plru_tree_t;

  // Decoded request, shared by the victim and update paths
  typedef struct packed {
    logic       hit_vld;
    entry_idx_t hit_idx;
    logic       any_invalid;
    entry_idx_t free_idx;
    logic       refill_vld;
  } plru_lookup_t;

endpackage

//--- verilog/plru_decode.sv
module plru_decode (
  input  plru_pkg::entry_vec_t   i_entry_vld,
  input  logic                   i_hit_vld,
  input  plru_pkg::entry_vec_t   i_hit_onehot,
  input  logic                   i_refill_vld,
  output plru_pkg::plru_lookup_t o_lookup
);

  import plru_pkg::*;

  entry_idx_t hit_idx;
  entry_idx_t free_idx;
  logic       any_invalid;

  //--------------------------------------------------------------------
  // Hit vector to index
  //--------------------------------------------------------------------

  // OR of the indices of all set bits
  // Exact for a one-hot vector
  always_comb begin
    hit_idx = '0;
    for (int i = 0; i < ENTRY_NUM; i++) begin
      if (i_hit_onehot[i]) begin
        hit_idx = hit_idx | entry_idx_t'(i);
      end
    end
  end

  //--------------------------------------------------------------------
  // Lowest invalid entry
  //--------------------------------------------------------------------

  // Scan from the top so the lowest invalid entry wins
  always_comb begin
    free_idx = '0;
    for (int i = ENTRY_NUM - 1; i >= 0; i--) begin
      if (!i_entry_vld[i]) begin
        free_idx = entry_idx_t'(i);
      end
    end
  end

  assign any_invalid = ~&i_entry_vld;

  //--------------------------------------------------------------------
  // Request struct
  //--------------------------------------------------------------------

  always_comb begin
    o_lookup             = '0;
    o_lookup.hit_vld     = i_hit_vld;
    o_lookup.hit_idx     = hit_idx;
    o_lookup.any_invalid = any_invalid;
    o_lookup.free_idx    = free_idx;
    o_lookup.refill_vld  = i_refill_vld;
  end

endmodule

//--- verilog/plru_execute.sv
module plru_execute (
  input  logic                 forever_cpuclk,
  input  logic                 i_rst,
  input  logic                 i_touch_vld,
  input  plru_pkg::entry_idx_t i_touch_idx,
  output plru_pkg::plru_tree_t o_tree
);

  import plru_pkg::*;

  plru_tree_t tree_q;
  plru_tree_t tree_nxt;

  //--------------------------------------------------------------------
  // Touch update
  //--------------------------------------------------------------------

  // Tree layout, heap numbered
  //
  //                    0
  //              /          \
  //            1              2
  //          /   \          /   \
  //         3     4        5     6
  //        ...                  ...
  //       15 16  ......        29 30
  //
  // Leaf pairs under nodes 15..30 are the 32 entries

  // Root to leaf, the index MSB picks the first branch
  // Each node on the path is pointed away from the touched entry
  always_comb begin
    int   node;
    logic dir;

    tree_nxt = tree_q;
    node     = 0;
    for (int lvl = 0; lvl < IDX_W; lvl++) begin
      dir            = i_touch_idx[IDX_W-1-lvl];
      tree_nxt[node] = ~dir;
      node           = 2 * node + 1 + int'(dir);
    end
  end

  //--------------------------------------------------------------------
  // Node flops
  //--------------------------------------------------------------------

  // All zero after reset, so entry 0 is the first victim
  always_ff @(posedge forever_cpuclk) begin
    if (i_rst) begin
      tree_q <= '0;
    end else if (i_touch_vld) begin
      tree_q <= tree_nxt;
    end
  end

  assign o_tree = tree_q;

endmodule

//--- verilog/plru_result.sv
module plru_result (
  input  plru_pkg::plru_lookup_t i_lookup,
  input  plru_pkg::plru_tree_t   i_tree,
  output logic                   o_touch_vld,
  output plru_pkg::entry_idx_t   o_touch_idx,
  output plru_pkg::entry_vec_t   o_refill_onehot
);

  import plru_pkg::*;

  entry_idx_t victim_idx;
  entry_idx_t refill_idx;

  //--------------------------------------------------------------------
  // Tree walk
  //--------------------------------------------------------------------

  // Follow the node bits down, one index bit per level
  always_comb begin
    int   node;
    logic dir;

    victim_idx = '0;
    node       = 0;
    for (int lvl = 0; lvl < IDX_W; lvl++) begin
      dir                       = i_tree[node];
      victim_idx[IDX_W-1-lvl]   = dir;
      node                      = 2 * node + 1 + int'(dir);
    end
  end

  //--------------------------------------------------------------------
  // Refill target
  //--------------------------------------------------------------------

  // An empty slot is always filled before anything is evicted
  assign refill_idx = i_lookup.any_invalid ? i_lookup.free_idx : victim_idx;

  always_comb begin
    o_refill_onehot             = '0;
    o_refill_onehot[refill_idx] = 1'b1;
  end

  //--------------------------------------------------------------------
  // Entry to mark as used
  //--------------------------------------------------------------------

  // Hit wins over refill when both strobes are set
  assign o_touch_vld = i_lookup.hit_vld | i_lookup.refill_vld;
  assign o_touch_idx = i_lookup.hit_vld ? i_lookup.hit_idx : refill_idx;

endmodule

//--- verilog/utlb_plru.sv
module utlb_plru (
  input  logic                 forever_cpuclk,
  input  logic                 i_rst,
  input  plru_pkg::entry_vec_t i_entry_vld,
  input  logic                 i_hit_vld,
  input  plru_pkg::entry_vec_t i_hit_onehot,
  input  logic                 i_refill_vld,
  output plru_pkg::entry_vec_t o_refill_onehot
);

  import plru_pkg::*;

  plru_lookup_t lookup;
  plru_tree_t   tree;
  entry_idx_t   touch_idx;
  logic         touch_vld;

  // Valid bits and strobes to indices
  plru_decode u_decode (
    .i_entry_vld  (i_entry_vld),
    .i_hit_vld    (i_hit_vld),
    .i_hit_onehot (i_hit_onehot),
    .i_refill_vld (i_refill_vld),
    .o_lookup     (lookup)
  );

  // Victim walk and refill target
  plru_result u_result (
    .i_lookup        (lookup),
    .i_tree          (tree),
    .o_touch_vld     (touch_vld),
    .o_touch_idx     (touch_idx),
    .o_refill_onehot (o_refill_onehot)
  );

  // Tree state, one cycle update
  plru_execute u_execute (
    .forever_cpuclk (forever_cpuclk),
    .i_rst          (i_rst),
    .i_touch_vld    (touch_vld),
    .i_touch_idx    (touch_idx),
    .o_tree         (tree)
  );

endmodule

//--- verif/utlb_plru_assert.sv
module utlb_plru_assert (
  input logic                 forever_cpuclk,
  input logic                 i_rst,
  input plru_pkg::entry_vec_t i_entry_vld,
  input logic                 i_hit_vld,
  input plru_pkg::entry_vec_t i_hit_onehot,
  input plru_pkg::entry_vec_t o_refill_onehot
);

  import plru_pkg::*;

  entry_vec_t free_vec;
  entry_vec_t lowest_free;

  // Invalid entries, and the lowest of them as a one-hot mask
  assign free_vec    = ~i_entry_vld;
  assign lowest_free = free_vec & (~free_vec + 1'b1);

  //--------------------------------------------------------------------
  // Output target
  //--------------------------------------------------------------------

  refill_free_a : assert property (
    @(posedge forever_cpuclk) disable iff (i_rst)
    (free_vec != '0) |-> (o_refill_onehot == lowest_free)
  ) else $error("o_refill_onehot does not select the lowest invalid entry");

  refill_known_a : assert property (
    @(posedge forever_cpuclk) disable iff (i_rst)
    !$isunknown(o_refill_onehot)
  ) else $error("o_refill_onehot holds X or Z bits");

  // Hit vector from the tag compare
  hit_onehot_a : assert property (
    @(posedge forever_cpuclk) disable iff (i_rst)
    i_hit_vld |-> $onehot(i_hit_onehot)
  ) else $error("i_hit_onehot is not one-hot while i_hit_vld is set");

endmodule

bind utlb_plru utlb_plru_assert u_assert (
  .forever_cpuclk  (forever_cpuclk),
  .i_rst           (i_rst),
  .i_entry_vld     (i_entry_vld),
  .i_hit_vld       (i_hit_vld),
  .i_hit_onehot    (i_hit_onehot),
  .o_refill_onehot (o_refill_onehot)
);

//--- verif/utlb_plru_tb.sv
module utlb_plru_tb;

  import plru_pkg::*;

  localparam int CLK_HALF     = 4;
  localparam int RESET_CYCLES = 10;
  localparam int TABLE_LEN    = 40;
  localparam int RAND_STEPS   = 200;
  localparam int MAX_CYCLES   = TABLE_LEN + RAND_STEPS + RESET_CYCLES + 50;

  localparam entry_vec_t ALL_VLD  = '1;
  // Entries 3 and 12 empty
  localparam entry_vec_t PART_VLD = 32'hffff_eff7;

  typedef struct packed {
    entry_vec_t entry_vld;
    logic       hit_vld;
    entry_vec_t hit_onehot;
    logic       refill_vld;
    entry_vec_t exp_target;
  } stim_row_t;

  logic       forever_cpuclk = 1'b0;
  logic       i_rst;
  entry_vec_t i_entry_vld;
  logic       i_hit_vld;
  entry_vec_t i_hit_onehot;
  logic       i_refill_vld;
  entry_vec_t o_refill_onehot;

  stim_row_t   stim_table [TABLE_LEN];
  int          row_cnt;
  plru_tree_t  model_tree;
  logic [31:0] lfsr_state;
  int          cycle_cnt = 0;
  int          error_count;

  utlb_plru u_dut (
    .forever_cpuclk  (forever_cpuclk),
    .i_rst           (i_rst),
    .i_entry_vld     (i_entry_vld),
    .i_hit_vld       (i_hit_vld),
    .i_hit_onehot    (i_hit_onehot),
    .i_refill_vld    (i_refill_vld),
    .o_refill_onehot (o_refill_onehot)
  );

  always #CLK_HALF forever_cpuclk = ~forever_cpuclk;

  always @(posedge forever_cpuclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: run did not end within %0d cycles", MAX_CYCLES);
      $display("Simulation failed");
      $fatal(1, "Timeout");
    end
  end

  //--------------------------------------------------------------------
  // Helpers
  //--------------------------------------------------------------------

  function automatic entry_vec_t onehot(input entry_idx_t idx);
    return entry_vec_t'(1) << idx;
  endfunction

  // Order in which a cleared tree hands out victims
  function automatic entry_idx_t bit_reverse(input entry_idx_t idx);
    entry_idx_t rev;
    for (int i = 0; i < IDX_W; i++) begin
      rev[i] = idx[IDX_W-1-i];
    end
    return rev;
  endfunction

  // Taps 32, 22, 2, 1
  function automatic logic lfsr_bit();
    logic fb;
    fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], lfsr_bit()};
    end
    return val;
  endfunction

  //--------------------------------------------------------------------
  // Reference model
  //--------------------------------------------------------------------

  // Node of level l under path prefix p is 2^l - 1 + p
  function automatic entry_idx_t model_victim(input plru_tree_t tree);
    int prefix;
    prefix = 0;
    for (int lvl = 0; lvl < IDX_W; lvl++) begin
      prefix = 2 * prefix + int'(tree[(1 << lvl) - 1 + prefix]);
    end
    return entry_idx_t'(prefix);
  endfunction

  function automatic plru_tree_t model_touch(input plru_tree_t tree, input entry_idx_t idx);
    plru_tree_t t;
    int         prefix;
    logic       b;
    t = tree;
    for (int lvl = 0; lvl < IDX_W; lvl++) begin
      prefix                  = int'(idx) >> (IDX_W - lvl);
      b                       = idx[IDX_W-1-lvl];
      t[(1 << lvl) - 1 + prefix] = ~b;
    end
    return t;
  endfunction

  function automatic entry_idx_t model_target_idx(input plru_tree_t tree,
                                                  input entry_vec_t vld);
    entry_idx_t idx;
    logic       found;
    idx   = model_victim(tree);
    found = 1'b0;
    for (int i = 0; i < ENTRY_NUM; i++) begin
      if (!found && !vld[i]) begin
        idx   = entry_idx_t'(i);
        found = 1'b1;
      end
    end
    return idx;
  endfunction

  function automatic entry_idx_t touched_idx(input stim_row_t row, input plru_tree_t tree);
    entry_idx_t idx;
    idx = model_target_idx(tree, row.entry_vld);
    for (int i = 0; i < ENTRY_NUM; i++) begin
      if (row.hit_vld && row.hit_onehot[i]) begin
        idx = entry_idx_t'(i);
      end
    end
    return idx;
  endfunction

  //--------------------------------------------------------------------
  // Stimulus
  //--------------------------------------------------------------------

  task automatic add_row(input entry_vec_t vld, input logic hit, input entry_idx_t hit_idx,
                         input logic refill, input entry_idx_t exp_idx);
    stim_table[row_cnt].entry_vld  = vld;
    stim_table[row_cnt].hit_vld    = hit;
    stim_table[row_cnt].hit_onehot = hit ? onehot(hit_idx) : '0;
    stim_table[row_cnt].refill_vld = refill;
    stim_table[row_cnt].exp_target = onehot(exp_idx);
    row_cnt++;
  endtask

  task automatic build_table();
    add_row(ALL_VLD, 1'b0, 5'd0, 1'b0, 5'd0);
    for (int i = 0; i < ENTRY_NUM; i++) begin
      add_row(ALL_VLD, 1'b0, 5'd0, 1'b1, bit_reverse(entry_idx_t'(i)));
    end
    // Back to a cleared tree
    add_row(ALL_VLD, 1'b0, 5'd0, 1'b0, 5'd0);
    add_row(ALL_VLD, 1'b1, 5'd0, 1'b0, 5'd0);
    // Hit on 5 with refill, victim 16 stays put
    add_row(ALL_VLD, 1'b1, 5'd5, 1'b1, 5'd16);
    add_row(ALL_VLD, 1'b0, 5'd0, 1'b1, 5'd16);
    add_row(PART_VLD, 1'b0, 5'd0, 1'b0, 5'd3);
    add_row(PART_VLD, 1'b0, 5'd0, 1'b1, 5'd3);
    add_row(ALL_VLD, 1'b0, 5'd0, 1'b0, 5'd24);
  endtask

  task automatic check_target(input entry_vec_t exp);
    assert (o_refill_onehot === exp) else begin
      error_count++;
      $display("Error: time %0t o_refill_onehot expected %h actual %h",
               $time, exp, o_refill_onehot);
      $display("Simulation failed");
      $fatal(1, "Refill target mismatch");
    end
  endtask

  task automatic apply_row(input stim_row_t row);
    @(negedge forever_cpuclk);
    i_entry_vld  = row.entry_vld;
    i_hit_vld    = row.hit_vld;
    i_hit_onehot = row.hit_onehot;
    i_refill_vld = row.refill_vld;
    #(CLK_HALF / 2);
    check_target(row.exp_target);
    if (row.hit_vld || row.refill_vld) begin
      model_tree = model_touch(model_tree, touched_idx(row, model_tree));
    end
  endtask

  task automatic random_step();
    stim_row_t  row;
    logic [1:0] mode;
    logic [1:0] op;
    entry_idx_t hidx;
    mode           = 2'(lfsr_bits(2));
    row.entry_vld  = (mode == 2'd0) ? lfsr_bits(32) : ALL_VLD;
    op             = 2'(lfsr_bits(2));
    hidx           = entry_idx_t'(lfsr_bits(IDX_W));
    row.hit_vld    = op[0];
    row.refill_vld = op[1];
    row.hit_onehot = onehot(hidx);
    row.exp_target = onehot(model_target_idx(model_tree, row.entry_vld));
    apply_row(row);
  endtask

  initial begin
    lfsr_state   = 32'hb526_2331;
    row_cnt      = 0;
    error_count  = 0;
    model_tree   = '0;
    i_rst        = 1'b1;
    i_entry_vld  = '1;
    i_hit_vld    = 1'b0;
    i_hit_onehot = '0;
    i_refill_vld = 1'b0;

    build_table();
    assert (row_cnt == TABLE_LEN) else begin
      $display("Stimulus table holds %0d rows instead of %0d", row_cnt, TABLE_LEN);
      $display("Simulation failed");
      $fatal(1, "Table size");
    end

    repeat (RESET_CYCLES) @(posedge forever_cpuclk);
    @(negedge forever_cpuclk);
    i_rst = 1'b0;

    for (int r = 0; r < TABLE_LEN; r++) begin
      apply_row(stim_table[r]);
    end
    for (int s = 0; s < RAND_STEPS; s++) begin
      random_step();
    end

    @(negedge forever_cpuclk);
    i_hit_vld    = 1'b0;
    i_refill_vld = 1'b0;
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- verilog.f
verilog/plru_pkg.sv
verilog/plru_decode.sv
verilog/plru_execute.sv
verilog/plru_result.sv
verilog/utlb_plru.sv
verif/utlb_plru_assert.sv
verif/utlb_plru_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the utlb_plru testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --top-module utlb_plru_tb \
  -f verilog.f -o sim_utlb_plru > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/sim_utlb_plru > sim.log 2>&1
cat sim.log

grep -q "Simulation completed successfully" sim.log \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
